/* design/atari_io_macros.svh */
/*
 * Shared constants for the ROM store and the mouse stick emulation.
 * Include wherever a ROM width, the pad byte or a mouse limit is needed.
 */
`ifndef ATARI_IO_MACROS_SVH
`define ATARI_IO_MACROS_SVH

// ==============================
// ROM geometry
// ==============================
// CPU side ROM address, covers 0x0000..0x7FFF of the ROM space
`define ROM_ADDR_W      15
// XL, OS-A and OS-B banks are 16 KB windows
`define OS_ADDR_W       14
// BASIC cartridge area is 8 KB
`define BASIC_ADDR_W    13
// Value returned from space with no image behind it
`define ROM_PAD_BYTE    8'hFF

// ==============================
// Mouse to stick limits
// ==============================
`define MOUSE_STEP_MAX  10
`define AXIS_MIN        (-128)
`define AXIS_MAX        127

`endif

/* design/rom_pkg.sv */
/*
 * Types for the system ROM store.
 * Covers the CPU ROM address, data bytes, download index codes,
 * the machine selection and the registered read mux choice.
 */
`default_nettype none
`include "atari_io_macros.svh"

package rom_pkg;

	typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;
	typedef logic [7:0]             rom_byte_t;
	typedef logic [5:0]             dl_index_t;

	// Machine selection, latched while the core is in reset
	typedef enum logic [1:0] {
		MSEL_XL_BASIC = 2'd0,
		MSEL_XL       = 2'd1,
		MSEL_800_OSA  = 2'd2,
		MSEL_800_OSB  = 2'd3
	} machine_sel_t;

	// Download index of each ROM image
	localparam dl_index_t IDX_XL    = 6'd4;
	localparam dl_index_t IDX_BASIC = 6'd5;
	localparam dl_index_t IDX_OSA   = 6'd6;
	localparam dl_index_t IDX_OSB   = 6'd7;

	// Which bank answers a read, carried one cycle with the address
	typedef enum logic [2:0] {
		SRC_PAD,
		SRC_BASIC,
		SRC_XL,
		SRC_OSA,
		SRC_OSB
	} rom_src_t;

endpackage

`default_nettype wire

/* design/input_pkg.sv */
/*
 * Types for the mouse packet and the analog stick axes.
 * The packet layout is the PS/2 style word of the host interface.
 */
`default_nettype none

package input_pkg;

	// Mouse packet, 25 bits, toggle strobe on top
	typedef struct packed {
		logic       stb;        // 24, toggles once per packet
		logic [6:0] dy;         // 23:17
		logic       rsv_16;
		logic [6:0] dx;         // 15:9
		logic       rsv_8;
		logic [1:0] ovf;        // 7:6 overflow flags
		logic       y_sign;     // 5
		logic       x_sign;     // 4
		logic [1:0] rsv_3_2;
		logic [1:0] buttons;    // 1:0
	} mouse_pkt_t;

	// Stick position, two's complement
	typedef logic signed [7:0] axis_t;

endpackage

`default_nettype wire

/* design/rom_bank.sv */
/*
 * One downloadable ROM bank, a byte array with a registered read port.
 * With ALIGN_TOP set, each write moves the image so that the last byte
 * of an ascending load sits at the top of the window. Reads below the
 * image start return the pad byte. Read latency is one cycle.
 */
`timescale 1ns/100ps
`default_nettype none
`include "atari_io_macros.svh"

module rom_bank #(
	parameter int ADDR_W    = `OS_ADDR_W,
	parameter bit ALIGN_TOP = 1'b1
) (
	input  wire                     clk_sys,
	input  wire                     areset,
	input  wire                     wr_en_i,
	input  wire [ADDR_W-1:0]        wr_addr_i,
	input  wire rom_pkg::rom_byte_t wr_data_i,
	input  wire [ADDR_W-1:0]        rd_addr_i,
	output rom_pkg::rom_byte_t      rd_data_o
);

	localparam logic [ADDR_W-1:0] WIN_TOP = '1;
	localparam int DEPTH = 1 << ADDR_W;

	rom_pkg::rom_byte_t mem [DEPTH];
	rom_pkg::rom_byte_t mem_q;
	logic [ADDR_W-1:0]  offset;
	logic [ADDR_W-1:0]  mem_rd_addr;
	logic               below_q;

	// Empty bank reads as pad
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = `ROM_PAD_BYTE;
		end
	end

	// ==============================
	// Image offset
	// ==============================
	// Stays zero in a bank that is not aligned
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			offset <= '0;
		end else if (wr_en_i && ALIGN_TOP) begin
			offset <= WIN_TOP - wr_addr_i;
		end
	end

	// ==============================
	// Storage
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	assign mem_rd_addr = rd_addr_i - offset;

	// Pad decision registered next to the data so both line up
	always_ff @(posedge clk_sys) begin
		mem_q   <= mem[mem_rd_addr];
		below_q <= (rd_addr_i < offset);
	end

	assign rd_data_o = below_q ? `ROM_PAD_BYTE : mem_q;

	// Offset only moves on a download write
	a_offset_hold : assert property (@(posedge clk_sys) disable iff (areset)
		!wr_en_i |=> $stable(offset));

endmodule

`default_nettype wire

/* design/rom_store.sv */
/*
 * System ROM store with the XL OS, BASIC, OS-A and OS-B banks.
 * Downloads are routed by index, the machine selection is latched
 * during reset, and the read mux picks the bank for a CPU ROM address.
 * Read data is valid one cycle after the address.
 */
`timescale 1ns/100ps
`default_nettype none
`include "atari_io_macros.svh"

module rom_store (
	input  wire                        clk_sys,
	input  wire                        areset,
	input  wire                        dl_wr_i,
	input  wire rom_pkg::dl_index_t    dl_index_i,
	input  wire [`OS_ADDR_W-1:0]       dl_addr_i,
	input  wire rom_pkg::rom_byte_t    dl_data_i,
	input  wire rom_pkg::machine_sel_t machine_sel_i,
	input  wire rom_pkg::rom_addr_t    rom_addr_i,
	output rom_pkg::rom_byte_t         rom_data_o
);

	localparam int A_HI = `ROM_ADDR_W - 1;

	rom_pkg::machine_sel_t msel_q;
	rom_pkg::rom_src_t     src_d;
	rom_pkg::rom_src_t     src_q;
	logic                  wr_xl;
	logic                  wr_basic;
	logic                  wr_osa;
	logic                  wr_osb;
	rom_pkg::rom_byte_t    xl_do;
	rom_pkg::rom_byte_t    basic_do;
	rom_pkg::rom_byte_t    osa_do;
	rom_pkg::rom_byte_t    osb_do;

	// ==============================
	// Download decode
	// ==============================
	assign wr_xl    = dl_wr_i && (dl_index_i == rom_pkg::IDX_XL);
	assign wr_basic = dl_wr_i && (dl_index_i == rom_pkg::IDX_BASIC);
	assign wr_osa   = dl_wr_i && (dl_index_i == rom_pkg::IDX_OSA);
	assign wr_osb   = dl_wr_i && (dl_index_i == rom_pkg::IDX_OSB);

	// Selection follows the input during reset and holds afterwards
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			msel_q <= machine_sel_i;
		end
	end

	// ==============================
	// Read mux
	// ==============================
	always_comb begin
		src_d = rom_pkg::SRC_PAD;
		if (rom_addr_i[A_HI -: 2] == 2'b00 && msel_q == rom_pkg::MSEL_XL_BASIC) begin
			src_d = rom_pkg::SRC_BASIC;
		end else if (rom_addr_i[A_HI]) begin
			if (!msel_q[1]) begin
				src_d = rom_pkg::SRC_XL;
			end else if (msel_q[0]) begin
				src_d = rom_pkg::SRC_OSB;
			end else begin
				src_d = rom_pkg::SRC_OSA;
			end
		end
	end

	// Choice travels with the address to meet the bank outputs
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			src_q <= rom_pkg::SRC_PAD;
		end else begin
			src_q <= src_d;
		end
	end

	always_comb begin
		unique case (src_q)
			rom_pkg::SRC_BASIC: rom_data_o = basic_do;
			rom_pkg::SRC_XL:    rom_data_o = xl_do;
			rom_pkg::SRC_OSA:   rom_data_o = osa_do;
			rom_pkg::SRC_OSB:   rom_data_o = osb_do;
			default:            rom_data_o = `ROM_PAD_BYTE;
		endcase
	end

	// ==============================
	// Banks
	// ==============================
	rom_bank #(.ADDR_W(`OS_ADDR_W), .ALIGN_TOP(1'b1)) u_xl (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.wr_en_i   (wr_xl),
		.wr_addr_i (dl_addr_i),
		.wr_data_i (dl_data_i),
		.rd_addr_i (rom_addr_i[`OS_ADDR_W-1:0]),
		.rd_data_o (xl_do)
	);

	// BASIC is a plain 8 KB image, no alignment
	rom_bank #(.ADDR_W(`BASIC_ADDR_W), .ALIGN_TOP(1'b0)) u_basic (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.wr_en_i   (wr_basic),
		.wr_addr_i (dl_addr_i[`BASIC_ADDR_W-1:0]),
		.wr_data_i (dl_data_i),
		.rd_addr_i (rom_addr_i[`BASIC_ADDR_W-1:0]),
		.rd_data_o (basic_do)
	);

	rom_bank #(.ADDR_W(`OS_ADDR_W), .ALIGN_TOP(1'b1)) u_osa (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.wr_en_i   (wr_osa),
		.wr_addr_i (dl_addr_i),
		.wr_data_i (dl_data_i),
		.rd_addr_i (rom_addr_i[`OS_ADDR_W-1:0]),
		.rd_data_o (osa_do)
	);

	rom_bank #(.ADDR_W(`OS_ADDR_W), .ALIGN_TOP(1'b1)) u_osb (
		.clk_sys   (clk_sys),
		.areset    (areset),
		.wr_en_i   (wr_osb),
		.wr_addr_i (dl_addr_i),
		.wr_data_i (dl_data_i),
		.rd_addr_i (rom_addr_i[`OS_ADDR_W-1:0]),
		.rd_data_o (osb_do)
	);

	a_one_bank_write : assert property (@(posedge clk_sys) disable iff (areset)
		$onehot0({wr_xl, wr_basic, wr_osa, wr_osb}));

endmodule

`default_nettype wire

/* design/mouse_stick_emu.sv */
/*
 * Mouse to analog stick emulation.
 * Each mouse packet moves the stick by a clamped step, with optional
 * inversion per axis, saturated to the signed 8-bit range. A moving
 * real stick or a CPU halt hands control back and clears the position.
 */
`timescale 1ns/100ps
`default_nettype none
`include "atari_io_macros.svh"

module mouse_stick_emu (
	input  wire                     clk_sys,
	input  wire                     areset,
	input  wire input_pkg::mouse_pkt_t mouse_pkt_i,
	input  wire [15:0]              joya_i,
	input  wire                     invert_x_i,
	input  wire                     invert_y_i,
	input  wire                     cpu_halt_i,
	output input_pkg::axis_t        axis_x_o,
	output input_pkg::axis_t        axis_y_o,
	output logic                    mouse_active_o
);

	localparam logic signed [8:0] STEP_HI = `MOUSE_STEP_MAX;
	localparam logic signed [8:0] STEP_LO = -`MOUSE_STEP_MAX;
	localparam logic signed [9:0] AXIS_LO = `AXIS_MIN;
	localparam logic signed [9:0] AXIS_HI = `AXIS_MAX;

	input_pkg::mouse_pkt_t pkt_q;
	input_pkg::axis_t      pos_x;
	input_pkg::axis_t      pos_y;
	logic                  stb_q;
	logic                  clear;

	// One axis update: clamp the delta, apply it, saturate the sum
	function automatic input_pkg::axis_t axis_step(
		input input_pkg::axis_t pos,
		input logic             sign,
		input logic [6:0]       mag,
		input logic             invert
	);
		logic signed [8:0] delta;
		logic signed [8:0] step;
		logic signed [9:0] pos_w;
		logic signed [9:0] step_w;
		logic signed [9:0] sum;
		delta = {sign, sign, mag};
		if (delta > STEP_HI) begin
			step = STEP_HI;
		end else if (delta < STEP_LO) begin
			step = STEP_LO;
		end else begin
			step = delta;
		end
		pos_w  = pos;
		step_w = step;
		sum    = invert ? (pos_w - step_w) : (pos_w + step_w);
		if (sum > AXIS_HI) begin
			sum = AXIS_HI;
		end else if (sum < AXIS_LO) begin
			sum = AXIS_LO;
		end
		return input_pkg::axis_t'(sum[7:0]);
	endfunction

	assign clear = (|joya_i) || cpu_halt_i;

	// Packet sampled first, toggle checked against the copy behind it
	always_ff @(posedge clk_sys) begin
		pkt_q <= mouse_pkt_i;
		stb_q <= pkt_q.stb;
	end

	always_ff @(posedge clk_sys) begin
		if (areset || clear) begin
			mouse_active_o <= 1'b0;
			pos_x          <= '0;
			pos_y          <= '0;
		end else if (pkt_q.stb != stb_q) begin
			mouse_active_o <= 1'b1;
			pos_x <= axis_step(pos_x, pkt_q.x_sign, pkt_q.dx, invert_x_i);
			pos_y <= axis_step(pos_y, pkt_q.y_sign, pkt_q.dy, invert_y_i);
		end
	end

	// Real stick passes through while the mouse is idle
	assign axis_x_o = mouse_active_o ? pos_x : input_pkg::axis_t'(joya_i[7:0]);
	assign axis_y_o = mouse_active_o ? pos_y : input_pkg::axis_t'(joya_i[15:8]);

	a_step_bound : assert property (@(posedge clk_sys) disable iff (areset)
		(mouse_active_o && !clear) |=>
			((int'(pos_x) - int'($past(pos_x))) <= `MOUSE_STEP_MAX) &&
			((int'($past(pos_x)) - int'(pos_x)) <= `MOUSE_STEP_MAX) &&
			((int'(pos_y) - int'($past(pos_y))) <= `MOUSE_STEP_MAX) &&
			((int'($past(pos_y)) - int'(pos_y)) <= `MOUSE_STEP_MAX));

endmodule

`default_nettype wire

/* design/atari_io_top.sv */
/*
 * ROM and input subsystem of the 8-bit computer core.
 * Joins the system ROM store and the mouse stick emulation on clk_sys.
 */
`timescale 1ns/100ps
`default_nettype none
`include "atari_io_macros.svh"

module atari_io_top (
	input  wire                        clk_sys,
	input  wire                        areset,
	// Download port
	input  wire                        dl_wr_i,
	input  wire rom_pkg::dl_index_t    dl_index_i,
	input  wire [`OS_ADDR_W-1:0]       dl_addr_i,
	input  wire rom_pkg::rom_byte_t    dl_data_i,
	// CPU ROM side
	input  wire rom_pkg::machine_sel_t machine_sel_i,
	input  wire rom_pkg::rom_addr_t    rom_addr_i,
	output wire rom_pkg::rom_byte_t    rom_data_o,
	// Mouse and stick
	input  wire input_pkg::mouse_pkt_t mouse_pkt_i,
	input  wire [15:0]                 joya_i,
	input  wire                        invert_x_i,
	input  wire                        invert_y_i,
	input  wire                        cpu_halt_i,
	output wire input_pkg::axis_t      axis_x_o,
	output wire input_pkg::axis_t      axis_y_o,
	output wire                        mouse_active_o
);

	rom_store u_rom_store (
		.clk_sys       (clk_sys),
		.areset        (areset),
		.dl_wr_i       (dl_wr_i),
		.dl_index_i    (dl_index_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.machine_sel_i (machine_sel_i),
		.rom_addr_i    (rom_addr_i),
		.rom_data_o    (rom_data_o)
	);

	mouse_stick_emu u_mouse_stick_emu (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.mouse_pkt_i    (mouse_pkt_i),
		.joya_i         (joya_i),
		.invert_x_i     (invert_x_i),
		.invert_y_i     (invert_y_i),
		.cpu_halt_i     (cpu_halt_i),
		.axis_x_o       (axis_x_o),
		.axis_y_o       (axis_y_o),
		.mouse_active_o (mouse_active_o)
	);

endmodule

`default_nettype wire

/* dv/atari_io_tb.sv */
/*
 * Testbench for the ROM and input subsystem.
 * A reference model fills a table of download, read, mouse, joystick
 * and halt steps with expected values, then a loop applies the rows.
 */
`timescale 1ns/100ps
`default_nettype none
`include "atari_io_macros.svh"

module atari_io_tb;

	localparam logic [3:0] K_RESET = 4'd0;
	localparam logic [3:0] K_DL    = 4'd1;
	localparam logic [3:0] K_RD    = 4'd2;
	localparam logic [3:0] K_MOUSE = 4'd3;
	localparam logic [3:0] K_JOY   = 4'd4;
	localparam logic [3:0] K_HALT  = 4'd5;
	localparam logic [3:0] K_MSEL  = 4'd6;
	localparam int WIN_TOP = (1 << `OS_ADDR_W) - 1;
	localparam int PAD     = int'(`ROM_PAD_BYTE);

	typedef struct packed {
		logic [3:0]  kind;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] prev;
		logic [31:0] exp;
	} row_t;

	logic clk_sys, areset, dl_wr_i, invert_x_i, invert_y_i, cpu_halt_i, mouse_active_o;
	logic [5:0]  dl_index_i;
	logic [13:0] dl_addr_i;
	logic [7:0]  dl_data_i, rom_data_o, axis_x_o, axis_y_o;
	logic [14:0] rom_addr_i;
	logic [24:0] mouse_pkt_i;
	logic [15:0] joya_i;
	rom_pkg::machine_sel_t machine_sel_i;

	row_t tbl[$];
	int   ref_mem [int];
	int   ref_off [4];
	int   ref_sel, ref_x, ref_y, ref_active, ref_joy, ref_halt, ref_stb;
	int   tbl_cycles = 0, cycle_cnt = 0, cycle_limit = 0, errors = 0, checks = 0;
	int   seed = 32'h1bb93f7f;

	atari_io_top uut (.*);

	always #5 clk_sys = ~clk_sys;

	// Image byte, depends on the image and every address bit
	function automatic int rom_byte(input int idx, input int addr);
		return (addr * 13 + (addr >> 6) * 5 + idx * 41) & 255;
	endfunction

	task automatic add_row(input logic [3:0] kind, input int f0, input int f1,
			input int prev, input int exp, input int cyc);
		row_t r;
		r.kind = kind;
		r.f0   = f0;
		r.f1   = f1;
		r.prev = prev;
		r.exp  = exp;
		tbl.push_back(r);
		tbl_cycles += cyc;
	endtask

	function automatic int stick_out();
		if (ref_active != 0) begin
			return (1 << 16) | ((ref_y & 255) << 8) | (ref_x & 255);
		end
		return ref_joy;
	endfunction

	// ==============================
	// Reference model
	// ==============================
	task automatic model_reset(input int sel);
		ref_sel = sel;
		for (int b = 0; b < 4; b++) begin
			ref_off[b] = 0;
		end
		ref_x      = 0;
		ref_y      = 0;
		ref_active = 0;
		add_row(K_RESET, sel, 0, 0, 0, 9);
	endtask

	// Banks 0 to 3 are XL, BASIC, OS-A and OS-B, only BASIC stays unaligned
	task automatic model_load(input int bank, input int idx, input int len);
		for (int a = 0; a < len; a++) begin
			ref_mem[bank * 65536 + a] = rom_byte(idx, a);
			if (bank != 1) begin
				ref_off[bank] = WIN_TOP - a;
			end
			add_row(K_DL, idx, a, 0, rom_byte(idx, a), 1);
		end
	endtask

	function automatic int bank_read(input int bank, input int a);
		int key;
		key = bank * 65536 + a - ref_off[bank];
		if (a < ref_off[bank] || !ref_mem.exists(key)) begin
			return PAD;
		end
		return ref_mem[key];
	endfunction

	task automatic model_read(input int addr);
		int exp;
		exp = PAD;
		if (addr[14:13] == 2'b00 && ref_sel == int'(rom_pkg::MSEL_XL_BASIC)) begin
			exp = bank_read(1, addr & 32'h1FFF);
		end else if (addr[14]) begin
			exp = bank_read(ref_sel[1] ? (ref_sel[0] ? 3 : 2) : 0, addr & WIN_TOP);
		end
		add_row(K_RD, addr, 0, 0, exp, 2);
	endtask

	function automatic int move_axis(input int pos, input int d, input int inv);
		int st;
		int sum;
		st  = (d > `MOUSE_STEP_MAX) ? `MOUSE_STEP_MAX : d;
		st  = (st < -`MOUSE_STEP_MAX) ? -`MOUSE_STEP_MAX : st;
		sum = (inv != 0) ? pos - st : pos + st;
		sum = (sum > `AXIS_MAX) ? `AXIS_MAX : sum;
		return (sum < `AXIS_MIN) ? `AXIS_MIN : sum;
	endfunction

	task automatic model_mouse(input int dx, input int dy, input int inv);
		logic [31:0] pkt;
		int prev;
		prev       = stick_out();
		ref_stb    = 1 - ref_stb;
		pkt        = '0;
		pkt[24]    = ref_stb[0];
		pkt[23:17] = dy[6:0];
		pkt[15:9]  = dx[6:0];
		pkt[5]     = (dy < 0);
		pkt[4]     = (dx < 0);
		if (ref_joy == 0 && ref_halt == 0) begin
			ref_x      = move_axis(ref_x, dx, inv & 1);
			ref_y      = move_axis(ref_y, dy, inv & 2);
			ref_active = 1;
		end
		add_row(K_MOUSE, pkt, inv, prev, stick_out(), 3);
	endtask

	// Joystick or halt row, either one takes the stick back from the mouse
	task automatic model_override(input logic [3:0] kind, input int val);
		if (kind == K_JOY) begin
			ref_joy = val;
		end else begin
			ref_halt = val;
		end
		if (ref_joy != 0 || ref_halt != 0) begin
			ref_x      = 0;
			ref_y      = 0;
			ref_active = 0;
		end
		add_row(kind, val, 0, 0, stick_out(), 2);
	endtask

	task automatic build_table();
		int dx;
		int dy;
		model_reset(int'(rom_pkg::MSEL_XL));
		model_load(0, int'(rom_pkg::IDX_XL), 32);
		model_read('h7FFF);
		model_read('h7FFE);
		model_read('h7FE0);
		model_read('h7FDF);
		model_read('h4000);
		model_load(1, int'(rom_pkg::IDX_BASIC), 16);
		model_read('h0006);
		model_read('h2005);
		model_reset(int'(rom_pkg::MSEL_XL_BASIC));
		for (int a = 0; a < 18; a += 3) begin
			model_read(a);
		end
		model_read('h2005);
		model_read('h4010);
		model_reset(int'(rom_pkg::MSEL_800_OSA));
		model_load(2, int'(rom_pkg::IDX_OSA), 16);
		model_load(3, int'(rom_pkg::IDX_OSB), 24);
		model_read('h7FFF);
		model_read('h7FF0);
		model_read('h7FEF);
		model_read('h0005);
		add_row(K_MSEL, int'(rom_pkg::MSEL_800_OSB), 0, 0, 0, 1);
		model_read('h7FFF);
		model_read('h7FF5);
		model_reset(int'(rom_pkg::MSEL_800_OSB));
		model_read('h4000);
		model_read('h4017);
		model_read('h4018);
		model_load(3, int'(rom_pkg::IDX_OSB), 24);
		model_read('h7FFF);
		model_read('h7FE8);
		model_read('h7FE7);
		// Stick walks into both rails, then inversion and overrides
		model_mouse(3, -2, 0);
		for (int i = 0; i < 14; i++) begin
			model_mouse(60, -60, 0);
		end
		model_mouse(5, 5, 3);
		model_mouse(-7, 9, 1);
		model_override(K_JOY, 'h4020);
		model_override(K_JOY, 0);
		for (int i = 0; i < 12; i++) begin
			dx = $random(seed) % 41;
			dy = $random(seed) % 41;
			model_mouse(dx, dy, i % 4);
		end
		model_override(K_HALT, 1);
		model_mouse(7, 7, 0);
		model_override(K_HALT, 0);
		model_mouse(-9, 4, 0);
	endtask

	// ==============================
	// Run the table
	// ==============================
	initial begin
		row_t row;
		logic [16:0] got;
		clk_sys       = 1'b0;
		areset        = 1'b1;
		dl_wr_i       = 1'b0;
		dl_index_i    = '0;
		dl_addr_i     = '0;
		dl_data_i     = '0;
		machine_sel_i = rom_pkg::MSEL_XL;
		rom_addr_i    = '0;
		mouse_pkt_i   = '0;
		joya_i        = '0;
		invert_x_i    = 1'b0;
		invert_y_i    = 1'b0;
		cpu_halt_i    = 1'b0;
		ref_joy       = 0;
		ref_halt      = 0;
		ref_stb       = 0;
		build_table();
		cycle_limit = 4 * tbl_cycles;
		foreach (tbl[i]) begin
			row = tbl[i];
			@(posedge clk_sys);
			dl_wr_i <= 1'b0;
			case (row.kind)
				K_RESET: begin
					areset        <= 1'b1;
					machine_sel_i <= rom_pkg::machine_sel_t'(row.f0[1:0]);
					repeat (8) @(posedge clk_sys);
					areset <= 1'b0;
				end
				K_DL: begin
					dl_wr_i    <= 1'b1;
					dl_index_i <= row.f0[5:0];
					dl_addr_i  <= row.f1[13:0];
					dl_data_i  <= row.exp[7:0];
				end
				K_MSEL: machine_sel_i <= rom_pkg::machine_sel_t'(row.f0[1:0]);
				K_RD: rom_addr_i <= row.f0[14:0];
				K_MOUSE: begin
					mouse_pkt_i <= row.f0[24:0];
					invert_x_i  <= row.f1[0];
					invert_y_i  <= row.f1[1];
					@(posedge clk_sys);
					@(negedge clk_sys);
					checks++;
					if ({mouse_active_o, axis_y_o, axis_x_o} !== row.prev[16:0]) begin
						errors++;
						$display("[ERROR] %0t: stick %h moved before its cycle, expected %h",
							$time, {mouse_active_o, axis_y_o, axis_x_o}, row.prev[16:0]);
					end
				end
				K_JOY: joya_i <= row.f0[15:0];
				default: cpu_halt_i <= row.f0[0];
			endcase
			if (row.kind >= K_RD && row.kind <= K_HALT) begin
				@(posedge clk_sys);
				// Next address goes in while the last one is checked
				if (row.kind == K_RD) begin
					rom_addr_i <= ~row.f0[14:0];
				end
				@(negedge clk_sys);
				if (row.kind == K_RD) begin
					got = {9'd0, rom_data_o};
				end else begin
					got = {mouse_active_o, axis_y_o, axis_x_o};
				end
				checks++;
				if (got !== row.exp[16:0]) begin
					errors++;
					$display("[ERROR] %0t: row %0d kind %0d input %h gave %h, expected %h",
						$time, i, row.kind, row.f0, got, row.exp[16:0]);
				end
			end
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout: the table did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/rom_pkg.sv
design/input_pkg.sv
design/rom_bank.sv
design/rom_store.sv
design/mouse_stick_emu.sv
design/atari_io_top.sv
dv/atari_io_tb.sv

/* Makefile */
# Verilator flow for the ROM and input subsystem
TOP := atari_io_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
